/* logic/ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

    // Address and data width of both masters
    localparam int BUS_W = 32;

    // One enable per byte lane of a data word
    localparam int WBEN_W = 4;

    // Transfer type codes of the master side
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Transfer sizes
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

endpackage

`default_nettype wire

/* logic/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // Targets behind the router
    typedef enum logic [1:0] {
        REGION_INST = 2'd0,
        REGION_DATA = 2'd1,
        REGION_REG  = 2'd2
    } region_e;

    // Set selects the peripheral register file
    localparam int REG_SEL_BIT = 15;

    // Between the two RAMs, set selects data RAM
    localparam int RAM_SEL_BIT = 14;

    // Lowest bit of the word address
    localparam int WORD_LSB = 2;

    // Favor after reset, 1 means dmem wins the first conflict
    localparam logic FAVOR_DMEM_INST = 1'b0;
    localparam logic FAVOR_DMEM_DATA = 1'b1;
    localparam logic FAVOR_DMEM_REG  = 1'b1;

endpackage

`default_nettype wire

/* logic/access_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface access_if
    import ahb_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int RAM_ADDR_W = 12
) ();

    // Access accepted at the previous edge, valid for one cycle
    logic                  valid;
    logic                  write;
    region_e               region;
    logic [RAM_ADDR_W-1:0] word_addr;
    logic [1:0]            byte_off;
    hsize_e                size;

    modport issue (output valid, write, region, word_addr, byte_off, size);

    modport take (input valid, write, region, word_addr, byte_off, size);

endinterface

`default_nettype wire

/* logic/grant_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module grant_arbiter
    import ahb_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int RAM_ADDR_W = 12
) (
    input  logic             clk,
    input  logic             reset,

    input  logic [BUS_W-1:0] imem_haddr,
    input  logic [1:0]       imem_htrans,
    input  logic [2:0]       imem_hsize,
    input  logic             imem_hwrite,

    input  logic [BUS_W-1:0] dmem_haddr,
    input  logic [1:0]       dmem_htrans,
    input  logic [2:0]       dmem_hsize,
    input  logic             dmem_hwrite,

    output logic             imem_hready,
    output logic             dmem_hready,

    access_if.issue          imem_acc,
    access_if.issue          dmem_acc
);

    // Indexed by region_e value
    localparam logic [2:0] FAVOR_RESET = {FAVOR_DMEM_REG, FAVOR_DMEM_DATA, FAVOR_DMEM_INST};

    region_e    imem_region;
    region_e    dmem_region;
    logic       wr_phase;
    logic       imem_elig;
    logic       dmem_elig;
    logic       conflict;
    logic       imem_take;
    logic       dmem_take;
    logic [2:0] favor_dmem;

    function automatic region_e decode_region(input logic [BUS_W-1:0] addr);
        region_e region;
        if (addr[REG_SEL_BIT]) begin
            region = REGION_REG;
        end else if (addr[RAM_SEL_BIT]) begin
            region = REGION_DATA;
        end else begin
            region = REGION_INST;
        end
        return region;
    endfunction

    //////////////////////////////////////////////////
    // Request decode and acceptance
    //////////////////////////////////////////////////

    always_comb begin
        imem_region = decode_region(imem_haddr);
        dmem_region = decode_region(dmem_haddr);

        // No new access while any write sits in its data phase
        wr_phase = (imem_acc.valid && imem_acc.write) || (dmem_acc.valid && dmem_acc.write);

        imem_elig = (htrans_e'(imem_htrans) == NONSEQ) && !imem_hready && !wr_phase;
        dmem_elig = (htrans_e'(dmem_htrans) == NONSEQ) && !dmem_hready && !wr_phase;

        conflict = imem_elig && dmem_elig && (imem_region == dmem_region);

        imem_take = imem_elig;
        dmem_take = dmem_elig;
        if (conflict) begin
            imem_take = !favor_dmem[imem_region];
            dmem_take = favor_dmem[imem_region];
        end else if (imem_elig && dmem_elig && imem_hwrite && dmem_hwrite) begin
            // Two writes to different targets go one at a time, dmem first
            imem_take = 1'b0;
        end
    end

    // Round robin per region, toggled only by a real conflict
    always_ff @(posedge clk) begin
        if (reset) begin
            favor_dmem <= FAVOR_RESET;
        end else if (conflict) begin
            favor_dmem[imem_region] <= !favor_dmem[imem_region];
        end
    end

    //////////////////////////////////////////////////
    // Registered accesses and hready
    //////////////////////////////////////////////////

    // Reads complete in the next cycle, writes one cycle after their data phase
    always_ff @(posedge clk) begin
        if (reset) begin
            imem_acc.valid <= 1'b0;
            dmem_acc.valid <= 1'b0;
            imem_hready    <= 1'b0;
            dmem_hready    <= 1'b0;
        end else begin
            imem_acc.valid <= imem_take;
            dmem_acc.valid <= dmem_take;
            imem_hready    <= (imem_take && !imem_hwrite) || (imem_acc.valid && imem_acc.write);
            dmem_hready    <= (dmem_take && !dmem_hwrite) || (dmem_acc.valid && dmem_acc.write);
        end
    end

    always_ff @(posedge clk) begin
        if (imem_take) begin
            imem_acc.write     <= imem_hwrite;
            imem_acc.region    <= imem_region;
            imem_acc.word_addr <= imem_haddr[WORD_LSB +: RAM_ADDR_W];
            imem_acc.byte_off  <= imem_haddr[WORD_LSB-1:0];
            imem_acc.size      <= hsize_e'(imem_hsize);
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_take) begin
            dmem_acc.write     <= dmem_hwrite;
            dmem_acc.region    <= dmem_region;
            dmem_acc.word_addr <= dmem_haddr[WORD_LSB +: RAM_ADDR_W];
            dmem_acc.byte_off  <= dmem_haddr[WORD_LSB-1:0];
            dmem_acc.size      <= hsize_e'(dmem_hsize);
        end
    end

endmodule

`default_nettype wire

/* logic/target_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module target_mux
    import ahb_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int RAM_ADDR_W = 12,
    parameter int REG_ADDR_W = 4
) (
    access_if.take                imem_acc,
    access_if.take                dmem_acc,
    input  logic [BUS_W-1:0]      imem_hwdata,
    input  logic [BUS_W-1:0]      dmem_hwdata,

    input  logic [BUS_W-1:0]      inst_read,
    output logic [BUS_W-1:0]      inst_write,
    output logic [RAM_ADDR_W-1:0] inst_addr,
    output logic [WBEN_W-1:0]     inst_wben,
    output logic                  inst_rwn,

    input  logic [BUS_W-1:0]      data_read,
    output logic [BUS_W-1:0]      data_write,
    output logic [RAM_ADDR_W-1:0] data_addr,
    output logic [WBEN_W-1:0]     data_wben,
    output logic                  data_rwn,

    input  logic [BUS_W-1:0]      reg_read,
    output logic [BUS_W-1:0]      reg_write,
    output logic [REG_ADDR_W-1:0] reg_addr,
    output logic [WBEN_W-1:0]     reg_wben,
    output logic                  reg_rwn,

    output logic [BUS_W-1:0]      imem_hrdata,
    output logic [BUS_W-1:0]      dmem_hrdata
);

    // What one master would put on a target port
    typedef struct packed {
        logic [BUS_W-1:0]      wdata;
        logic [RAM_ADDR_W-1:0] addr;
        logic [WBEN_W-1:0]     wben;
        logic                  rwn;
    } port_drive_t;

    localparam port_drive_t IDLE_DRIVE = '{wdata: '0, addr: '0, wben: '0, rwn: 1'b1};

    port_drive_t imem_drv;
    port_drive_t dmem_drv;
    port_drive_t inst_drv;
    port_drive_t data_drv;
    port_drive_t reg_drv;
    logic [2:0]  imem_hit;
    logic [2:0]  dmem_hit;

    function automatic logic [WBEN_W-1:0] lane_enables(input hsize_e size, input logic [1:0] off);
        logic [WBEN_W-1:0] en;
        case (size)
            BYTE:    en = WBEN_W'(1) << off;
            HALF:    en = (off == 2'd0) ? 4'b0011 : 4'b1100;
            default: en = '1;
        endcase
        return en;
    endfunction

    function automatic port_drive_t master_drive(
        input logic                  write,
        input logic [RAM_ADDR_W-1:0] addr,
        input hsize_e                size,
        input logic [1:0]            off,
        input logic [BUS_W-1:0]      hwdata
    );
        port_drive_t drv;
        drv.addr  = addr;
        drv.rwn   = !write;
        drv.wben  = write ? lane_enables(size, off) : '0;
        // Unshifted, lanes picked by wben alone
        drv.wdata = write ? hwdata : '0;
        return drv;
    endfunction

    // Arbiter never lets both masters hit the same target
    function automatic port_drive_t pick(
        input logic        imem_sel,
        input logic        dmem_sel,
        input port_drive_t imem_in,
        input port_drive_t dmem_in
    );
        port_drive_t drv;
        drv = IDLE_DRIVE;
        if (dmem_sel) begin
            drv = dmem_in;
        end else if (imem_sel) begin
            drv = imem_in;
        end
        return drv;
    endfunction

    function automatic logic [BUS_W-1:0] read_back(
        input logic             valid,
        input logic             write,
        input region_e          region,
        input logic [BUS_W-1:0] inst_rd,
        input logic [BUS_W-1:0] data_rd,
        input logic [BUS_W-1:0] reg_rd
    );
        logic [BUS_W-1:0] rd;
        rd = '0;
        if (valid && !write) begin
            case (region)
                REGION_INST: rd = inst_rd;
                REGION_DATA: rd = data_rd;
                REGION_REG:  rd = reg_rd;
                default:     rd = '0;
            endcase
        end
        return rd;
    endfunction

    //////////////////////////////////////////////////
    // Target side
    //////////////////////////////////////////////////

    always_comb begin
        imem_drv = master_drive(imem_acc.write, imem_acc.word_addr, imem_acc.size,
                                imem_acc.byte_off, imem_hwdata);
        dmem_drv = master_drive(dmem_acc.write, dmem_acc.word_addr, dmem_acc.size,
                                dmem_acc.byte_off, dmem_hwdata);
        // One-hot target select per master
        imem_hit = imem_acc.valid ? (3'b001 << imem_acc.region) : 3'b000;
        dmem_hit = dmem_acc.valid ? (3'b001 << dmem_acc.region) : 3'b000;
    end

    assign inst_drv = pick(imem_hit[REGION_INST], dmem_hit[REGION_INST], imem_drv, dmem_drv);
    assign data_drv = pick(imem_hit[REGION_DATA], dmem_hit[REGION_DATA], imem_drv, dmem_drv);
    assign reg_drv  = pick(imem_hit[REGION_REG], dmem_hit[REGION_REG], imem_drv, dmem_drv);

    assign inst_write = inst_drv.wdata;
    assign inst_addr  = inst_drv.addr;
    assign inst_wben  = inst_drv.wben;
    assign inst_rwn   = inst_drv.rwn;

    assign data_write = data_drv.wdata;
    assign data_addr  = data_drv.addr;
    assign data_wben  = data_drv.wben;
    assign data_rwn   = data_drv.rwn;

    // Register index sits in the low bits of the word address
    assign reg_write  = reg_drv.wdata;
    assign reg_addr   = reg_drv.addr[REG_ADDR_W-1:0];
    assign reg_wben   = reg_drv.wben;
    assign reg_rwn    = reg_drv.rwn;

    //////////////////////////////////////////////////
    // Read data back to the masters
    //////////////////////////////////////////////////

    assign imem_hrdata = read_back(imem_acc.valid, imem_acc.write, imem_acc.region,
                                   inst_read, data_read, reg_read);
    assign dmem_hrdata = read_back(dmem_acc.valid, dmem_acc.write, dmem_acc.region,
                                   inst_read, data_read, reg_read);

endmodule

`default_nettype wire

/* logic/router_top.sv */
`timescale 1ns/10ps
`default_nettype none

module router_top
    import ahb_pkg::*;
#(
    parameter int RAM_ADDR_W = 12,
    parameter int REG_ADDR_W = 4
) (
    input  logic                  clk,
    input  logic                  reset,

    // Core instruction bus
    input  logic [BUS_W-1:0]      imem_haddr,
    input  logic [BUS_W-1:0]      imem_hwdata,
    input  logic [1:0]            imem_htrans,
    input  logic [2:0]            imem_hsize,
    input  logic                  imem_hwrite,
    output logic [BUS_W-1:0]      imem_hrdata,
    output logic                  imem_hready,

    // Core data bus
    input  logic [BUS_W-1:0]      dmem_haddr,
    input  logic [BUS_W-1:0]      dmem_hwdata,
    input  logic [1:0]            dmem_htrans,
    input  logic [2:0]            dmem_hsize,
    input  logic                  dmem_hwrite,
    output logic [BUS_W-1:0]      dmem_hrdata,
    output logic                  dmem_hready,

    // Instruction RAM
    input  logic [BUS_W-1:0]      inst_read,
    output logic [BUS_W-1:0]      inst_write,
    output logic [RAM_ADDR_W-1:0] inst_addr,
    output logic [WBEN_W-1:0]     inst_wben,
    output logic                  inst_rwn,

    // Data RAM
    input  logic [BUS_W-1:0]      data_read,
    output logic [BUS_W-1:0]      data_write,
    output logic [RAM_ADDR_W-1:0] data_addr,
    output logic [WBEN_W-1:0]     data_wben,
    output logic                  data_rwn,

    // Peripheral register file
    input  logic [BUS_W-1:0]      reg_read,
    output logic [BUS_W-1:0]      reg_write,
    output logic [REG_ADDR_W-1:0] reg_addr,
    output logic [WBEN_W-1:0]     reg_wben,
    output logic                  reg_rwn
);

    access_if #(.RAM_ADDR_W(RAM_ADDR_W)) imem_acc ();
    access_if #(.RAM_ADDR_W(RAM_ADDR_W)) dmem_acc ();

    grant_arbiter #(
        .RAM_ADDR_W(RAM_ADDR_W)
    ) u_grant_arbiter (
        .clk(clk),           .reset(reset),
        .imem_haddr(imem_haddr),   .imem_htrans(imem_htrans),
        .imem_hsize(imem_hsize),   .imem_hwrite(imem_hwrite),
        .dmem_haddr(dmem_haddr),   .dmem_htrans(dmem_htrans),
        .dmem_hsize(dmem_hsize),   .dmem_hwrite(dmem_hwrite),
        .imem_hready(imem_hready), .dmem_hready(dmem_hready),
        .imem_acc(imem_acc.issue), .dmem_acc(dmem_acc.issue)
    );

    target_mux #(
        .RAM_ADDR_W(RAM_ADDR_W), .REG_ADDR_W(REG_ADDR_W)
    ) u_target_mux (
        .imem_acc(imem_acc.take),  .dmem_acc(dmem_acc.take),
        .imem_hwdata(imem_hwdata), .dmem_hwdata(dmem_hwdata),
        .inst_read(inst_read),  .inst_write(inst_write), .inst_addr(inst_addr),
        .inst_wben(inst_wben),  .inst_rwn(inst_rwn),
        .data_read(data_read),  .data_write(data_write), .data_addr(data_addr),
        .data_wben(data_wben),  .data_rwn(data_rwn),
        .reg_read(reg_read),    .reg_write(reg_write),   .reg_addr(reg_addr),
        .reg_wben(reg_wben),    .reg_rwn(reg_rwn),
        .imem_hrdata(imem_hrdata), .dmem_hrdata(dmem_hrdata)
    );

endmodule

`default_nettype wire

/* tests/router_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module router_assert
    import ahb_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic              imem_hready,
    input logic              dmem_hready,
    input logic [WBEN_W-1:0] inst_wben,
    input logic              inst_rwn,
    input logic [WBEN_W-1:0] data_wben,
    input logic              data_rwn,
    input logic [WBEN_W-1:0] reg_wben,
    input logic              reg_rwn
);

    int failures = 0;

    // Byte enables only in a write data phase
    a_inst_wben: assert property (@(posedge clk) disable iff (reset)
        (inst_wben != '0) |-> !inst_rwn)
        else begin
            $error("inst_wben nonzero while inst_rwn is high");
            failures++;
        end

    a_data_wben: assert property (@(posedge clk) disable iff (reset)
        (data_wben != '0) |-> !data_rwn)
        else begin
            $error("data_wben nonzero while data_rwn is high");
            failures++;
        end

    a_reg_wben: assert property (@(posedge clk) disable iff (reset)
        (reg_wben != '0) |-> !reg_rwn)
        else begin
            $error("reg_wben nonzero while reg_rwn is high");
            failures++;
        end

    // Completion is a single-cycle pulse
    a_imem_pulse: assert property (@(posedge clk) disable iff (reset)
        imem_hready |=> !imem_hready)
        else begin
            $error("imem_hready high for two cycles in a row");
            failures++;
        end

    a_dmem_pulse: assert property (@(posedge clk) disable iff (reset)
        dmem_hready |=> !dmem_hready)
        else begin
            $error("dmem_hready high for two cycles in a row");
            failures++;
        end

    a_reset_hready: assert property (@(posedge clk) reset |=> (!imem_hready && !dmem_hready))
        else begin
            $error("hready high in the cycle after reset");
            failures++;
        end

endmodule

bind router_top router_assert u_router_assert (
    .clk(clk),
    .reset(reset),
    .imem_hready(imem_hready),
    .dmem_hready(dmem_hready),
    .inst_wben(inst_wben),
    .inst_rwn(inst_rwn),
    .data_wben(data_wben),
    .data_rwn(data_rwn),
    .reg_wben(reg_wben),
    .reg_rwn(reg_rwn)
);

`default_nettype wire

/* tests/router_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module router_tb
    import ahb_pkg::*;
();

    // Tests run for about 400 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic             clk;
    logic             reset;
    logic [BUS_W-1:0] imem_haddr, imem_hwdata, imem_hrdata;
    logic [1:0]       imem_htrans;
    logic [2:0]       imem_hsize;
    logic             imem_hwrite, imem_hready;
    logic [BUS_W-1:0] dmem_haddr, dmem_hwdata, dmem_hrdata;
    logic [1:0]       dmem_htrans;
    logic [2:0]       dmem_hsize;
    logic             dmem_hwrite, dmem_hready;
    logic [31:0]      inst_read, inst_write, data_read, data_write, reg_read, reg_write;
    logic [11:0]      inst_addr, data_addr;
    logic [3:0]       reg_addr, inst_wben, data_wben, reg_wben;
    logic             inst_rwn, data_rwn, reg_rwn;

    logic [31:0] inst_mem [4096];
    logic [31:0] data_mem [4096];
    logic [31:0] reg_mem  [16];
    int          cycle = 0;
    int          errors = 0;

    router_top #(.RAM_ADDR_W(12), .REG_ADDR_W(4)) u_router_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Target memory models
    //////////////////////////////////////////////////

    assign inst_read = inst_mem[inst_addr];
    assign data_read = data_mem[data_addr];
    assign reg_read  = reg_mem[reg_addr];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (!inst_rwn && inst_wben[b])
                inst_mem[inst_addr][8*b +: 8] <= inst_write[8*b +: 8];
            if (!data_rwn && data_wben[b])
                data_mem[data_addr][8*b +: 8] <= data_write[8*b +: 8];
            if (!reg_rwn && reg_wben[b])
                reg_mem[reg_addr][8*b +: 8] <= reg_write[8*b +: 8];
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("ERROR: run stopped after %0d cycles, a transfer never completed", cycle);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Region index: 0 instruction RAM, 1 data RAM, 2 register file
    function automatic logic [31:0] region_addr(input int r, input logic [11:0] w,
                                                input logic [1:0] off);
        if (r == 2)
            return {16'h0, 1'b1, 9'h0, w[3:0], off};
        return {16'h0, 1'b0, (r == 1), w, off};
    endfunction

    function automatic logic [31:0] model_word(input int r, input logic [11:0] w);
        if (r == 0)
            return inst_mem[w];
        if (r == 1)
            return data_mem[w];
        return reg_mem[w[3:0]];
    endfunction

    function automatic logic [3:0] exp_wben(input logic [2:0] sz, input logic [1:0] off);
        if (sz == BYTE) begin
            case (off)
                2'd0: return 4'b0001;
                2'd1: return 4'b0010;
                2'd2: return 4'b0100;
                default: return 4'b1000;
            endcase
        end
        if (sz == HALF)
            return (off == 2'd0) ? 4'b0011 : 4'b1100;
        return 4'b1111;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] en);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (en[b])
                res[8*b +: 8] = wd[8*b +: 8];
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_sample();
        @(posedge clk);
        #5;
    endtask

    task automatic drive_req(input bit dm, input htrans_e tr, input bit wr,
                             input logic [31:0] addr, input logic [2:0] sz,
                             input logic [31:0] wd);
        if (dm) begin
            {dmem_htrans, dmem_hwrite, dmem_haddr, dmem_hsize, dmem_hwdata} = {tr, wr, addr, sz, wd};
        end else begin
            {imem_htrans, imem_hwrite, imem_haddr, imem_hsize, imem_hwdata} = {tr, wr, addr, sz, wd};
        end
    endtask

    // Starts 2 ns after an edge, returns 2 ns after the edge that ends the transfer
    task automatic bus_xfer(input bit dm, input bit wr, input logic [31:0] addr,
                            input logic [2:0] sz, input logic [31:0] wd,
                            output logic [31:0] rd, output int done);
        logic rdy;
        drive_req(dm, NONSEQ, wr, addr, sz, wd);
        do begin
            wait_sample();
            rdy = dm ? dmem_hready : imem_hready;
        end while (!rdy);
        rd = dm ? dmem_hrdata : imem_hrdata;
        done = cycle;
        @(posedge clk);
        #2;
        drive_req(dm, IDLE, 1'b0, 32'h0, WORD, 32'h0);
    endtask

    task automatic check_port(input int r, input logic [11:0] w, input logic [31:0] wd,
                              input logic [3:0] en);
        logic [11:0] addr;
        logic [31:0] wr;
        logic [3:0]  wben;
        logic        rwn;
        if (r == 0)
            {addr, wr, wben, rwn} = {inst_addr, inst_write, inst_wben, inst_rwn};
        else if (r == 1)
            {addr, wr, wben, rwn} = {data_addr, data_write, data_wben, data_rwn};
        else
            {addr, wr, wben, rwn} = {8'h0, reg_addr, reg_write, reg_wben, reg_rwn};
        check_value("writes addr", (r == 2) ? {8'h0, w[3:0]} : w, addr);
        check_value("writes data", wd, wr);
        check_value("writes wben", en, wben);
        check_value("writes rwn", 0, rwn);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        check_value("reset hready", 0, {imem_hready, dmem_hready});
        check_value("reset rwn", 3'b111, {inst_rwn, data_rwn, reg_rwn});
        check_value("reset wben", 0, {inst_wben, data_wben, reg_wben});
    endtask

    task automatic test_reads();
        logic [31:0] rd_i, rd_d;
        logic [11:0] wi, wd;
        int          start, done_i, done_d;
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < 3; r++) begin
                wi = 12'($urandom);
                start = cycle;
                bus_xfer(m[0], 1'b0, region_addr(r, wi, 2'd0), WORD, 32'h0, rd_i, done_i);
                check_value("reads data", model_word(r, wi), rd_i);
                check_value("reads latency", 1, done_i - start);
            end
        end
        // Different regions in the same cycle
        for (int r = 0; r < 2; r++) begin
            wi = 12'($urandom);
            wd = 12'($urandom);
            start = cycle;
            fork
                bus_xfer(1'b0, 1'b0, region_addr(r, wi, 2'd0), WORD, 32'h0, rd_i, done_i);
                bus_xfer(1'b1, 1'b0, region_addr(r + 1, wd, 2'd0), WORD, 32'h0, rd_d, done_d);
            join
            check_value("parallel reads imem", model_word(r, wi), rd_i);
            check_value("parallel reads dmem", model_word(r + 1, wd), rd_d);
            check_value("parallel reads imem latency", 1, done_i - start);
            check_value("parallel reads dmem latency", 1, done_d - start);
        end
    endtask

    task automatic test_writes();
        logic [31:0] wdata, exp_word, rd;
        logic [11:0] w;
        logic [3:0]  en;
        logic [2:0]  sz;
        bit          dm;
        int          start, done;
        for (int r = 0; r < 3; r++) begin
            for (int s = 0; s < 3; s++) begin
                for (int off = 0; off < 4; off++) begin
                    sz = 3'(s);
                    dm = 1'((r + s + off) % 2);
                    w = 12'($urandom);
                    wdata = $urandom;
                    en = exp_wben(sz, 2'(off));
                    exp_word = merge_lanes(model_word(r, w), wdata, en);
                    start = cycle;
                    fork
                        bus_xfer(dm, 1'b1, region_addr(r, w, 2'(off)), sz, wdata, rd, done);
                        begin
                            wait_sample();
                            check_port(r, w, wdata, en);
                        end
                    join
                    check_value("writes latency", 2, done - start);
                    bus_xfer(!dm, 1'b0, region_addr(r, w, 2'd0), WORD, 32'h0, rd, done);
                    check_value("writes readback", exp_word, rd);
                end
            end
        end
    endtask

    // Order code: 0 imem first, 1 dmem first, 2 same cycle
    task automatic test_conflict();
        logic [31:0] rd_i, rd_d;
        logic [11:0] wi, wd;
        int          done_i, done_d;
        logic        dmem_first;
        for (int r = 0; r < 3; r++) begin
            // Reset favor goes to imem for instruction RAM only
            dmem_first = (r != 0);
            for (int n = 0; n < 4; n++) begin
                wi = 12'($urandom);
                wd = 12'($urandom);
                fork
                    bus_xfer(1'b0, 1'b0, region_addr(r, wi, 2'd0), WORD, 32'h0, rd_i, done_i);
                    bus_xfer(1'b1, 1'b0, region_addr(r, wd, 2'd0), WORD, 32'h0, rd_d, done_d);
                join
                check_value("conflict order", dmem_first,
                            (done_i < done_d) ? 0 : (done_d < done_i) ? 1 : 2);
                check_value("conflict imem data", model_word(r, wi), rd_i);
                check_value("conflict dmem data", model_word(r, wd), rd_d);
                dmem_first = !dmem_first;
            end
        end
    endtask

    task automatic test_dual_write();
        logic [31:0] wdi, wdd, rd;
        logic [11:0] wi, wd;
        int          done_i, done_d;
        for (int p = 0; p < 2; p++) begin
            wi = 12'($urandom);
            wd = 12'($urandom);
            wdi = $urandom;
            wdd = $urandom;
            fork
                bus_xfer(1'b0, 1'b1, region_addr(p, wi, 2'd0), WORD, wdi, rd, done_i);
                bus_xfer(1'b1, 1'b1, region_addr(p + 1, wd, 2'd0), WORD, wdd, rd, done_d);
            join
            check_value("dual write order", 1,
                        (done_i < done_d) ? 0 : (done_d < done_i) ? 1 : 2);
            bus_xfer(1'b1, 1'b0, region_addr(p, wi, 2'd0), WORD, 32'h0, rd, done_i);
            check_value("dual write imem word", wdi, rd);
            bus_xfer(1'b0, 1'b0, region_addr(p + 1, wd, 2'd0), WORD, 32'h0, rd, done_d);
            check_value("dual write dmem word", wdd, rd);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h3dc13658));
        reset = 1'b1;
        drive_req(1'b0, IDLE, 1'b0, 32'h0, WORD, 32'h0);
        drive_req(1'b1, IDLE, 1'b0, 32'h0, WORD, 32'h0);
        for (int i = 0; i < 4096; i++) begin
            inst_mem[i] <= $urandom;
            data_mem[i] <= $urandom;
        end
        for (int i = 0; i < 16; i++)
            reg_mem[i] <= $urandom;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset();
        test_reads();
        test_writes();
        test_conflict();
        test_dual_write();
        errors += u_router_top.u_router_assert.failures;
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/ahb_pkg.sv
logic/mem_map_pkg.sv
logic/access_if.sv
logic/grant_arbiter.sv
logic/target_mux.sv
logic/router_top.sv
tests/router_assert.sv
tests/router_tb.sv
